// ==== src/rp_analog_pkg.sv ====
package rp_analog_pkg;

  ////////////////////////////////////////
  // converter geometry
  ////////////////////////////////////////

  // two converter channels, A and B
  localparam int unsigned N_CH = 2;

  localparam int unsigned ADC_DW = 14;  // raw deserialized ADC sample
  localparam int unsigned ADC_SW = 12;  // upper bits kept for the scope side

  // DAC code width, also width of generator and controller samples
  localparam int unsigned DAC_DW = 14;

  // one guard bit so that the sum of two full-scale samples still fits
  localparam int unsigned SUM_DW = DAC_DW + 1;

  ////////////////////////////////////////
  // saturation limits, two's complement
  ////////////////////////////////////////

  // largest positive code, 0x1fff
  localparam logic [DAC_DW-1:0] DAC_POS_MAX = {1'b0, {(DAC_DW-1){1'b1}}};

  // most negative code, 0x2000
  localparam logic [DAC_DW-1:0] DAC_NEG_MAX = {1'b1, {(DAC_DW-1){1'b0}}};

  ////////////////////////////////////////
  // diagnostics
  ////////////////////////////////////////

  // unlocked cycle counter, wide enough to never saturate in practice
  localparam int unsigned DIAG_W = 32;

  ////////////////////////////////////////
  // reset sequencer states
  ////////////////////////////////////////

  // ST_WAIT holds the converters off
  // ST_RUN means PLL locked and input delays calibrated
  typedef enum logic [0:0] {
    ST_WAIT = 1'b0,  // waiting for lock and delay-ready
    ST_RUN  = 1'b1   // converter path released
  } seq_state_e;

endpackage

// ==== src/reset_sequencer.sv ====
`timescale 1ns/10ps

module reset_sequencer (
  input  logic adc_clk,       // converter clock
  input  logic rst_i,         // synchronous active high reset
  input  logic pll_locked_i,  // clock PLL lock status
  input  logic idly_rdy_i,    // input delay block calibrated
  output logic run_o,         // converter path released
  output logic count_en_o     // unlocked cycle for diagnostics
);

////////////////////////////////////////
// state register
////////////////////////////////////////

rp_analog_pkg::seq_state_e state_q;  // current state
rp_analog_pkg::seq_state_e state_d;  // next state

logic clk_ok;  // both readiness conditions met this cycle

assign clk_ok = pll_locked_i & idly_rdy_i;

// next state
// leave ST_WAIT only when both conditions hold,
// drop back on any loss of either
always_comb begin
  state_d = state_q;
  case (state_q)
    rp_analog_pkg::ST_WAIT: begin
      if (clk_ok) begin
        state_d = rp_analog_pkg::ST_RUN;  // release next cycle
      end
    end
    rp_analog_pkg::ST_RUN: begin
      if (!clk_ok) begin
        state_d = rp_analog_pkg::ST_WAIT;  // lock or delay lost
      end
    end
    default: state_d = rp_analog_pkg::ST_WAIT;
  endcase
end

always_ff @(posedge adc_clk) begin
  if (rst_i) begin
    state_q <= rp_analog_pkg::ST_WAIT;
  end else begin
    state_q <= state_d;
  end
end

////////////////////////////////////////
// outputs
////////////////////////////////////////

assign run_o = (state_q == rp_analog_pkg::ST_RUN);  // released while in ST_RUN

// counter steering
// flags every cycle without PLL lock
assign count_en_o = ~pll_locked_i;

////////////////////////////////////////
// checks
////////////////////////////////////////

// released only when both inputs were good on the previous edge
a_run_needs_ready : assert property (
  @(posedge adc_clk) disable iff (rst_i)
  run_o |-> $past(pll_locked_i & idly_rdy_i)
);

endmodule

// ==== src/lock_loss_counter.sv ====
`timescale 1ns/10ps

module lock_loss_counter (
  input  logic                             adc_clk,     // converter clock
  input  logic                             rst_i,       // sync reset, active high
  input  logic                             count_en_i,  // PLL unlocked this cycle
  output logic [rp_analog_pkg::DIAG_W-1:0] diag_cnt_o   // total unlocked cycles
);

////////////////////////////////////////
// saturating counter
////////////////////////////////////////

logic [rp_analog_pkg::DIAG_W-1:0] cnt_q;  // running total
logic                             cnt_full;  // all ones reached

assign cnt_full = &cnt_q;

// count while unlocked
// stick at max so long outages never wrap to a small value
always_ff @(posedge adc_clk) begin
  if (rst_i) begin
    cnt_q <= '0;
  end else if (count_en_i && !cnt_full) begin
    cnt_q <= cnt_q + 1'b1;
  end
end

assign diag_cnt_o = cnt_q;

////////////////////////////////////////
// checks
////////////////////////////////////////

// total is monotonic between resets
a_cnt_monotonic : assert property (
  @(posedge adc_clk) disable iff (rst_i)
  !$past(rst_i) |-> (diag_cnt_o >= $past(diag_cnt_o))
);

endmodule

// ==== src/dac_backend.sv ====
`timescale 1ns/10ps

module dac_backend (
  input  logic                                                            adc_clk,
  input  logic                                                            rst_i,
  input  logic                                                            run_i,
  input  logic signed [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] asg_dat_i,
  input  logic signed [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] pid_dat_i,
  output logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_code_o,
  output logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_dat_o,
  output logic                                                            dac_reset_o
);

////////////////////////////////////////
// sum, saturation, inversion
////////////////////////////////////////

logic signed [rp_analog_pkg::SUM_DW-1:0] dac_sum [rp_analog_pkg::N_CH];  // one guard bit

logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_sat;  // clamped 2s compl
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_inv;  // neg slope code

logic [rp_analog_pkg::N_CH-1:0] ovf;  // sum left the 14 bit range

always_comb begin
  for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
    // both operands sign extended into the wider sum
    dac_sum[ch] = $signed(asg_dat_i[ch]) + $signed(pid_dat_i[ch]);

    // guard bit and msb disagree on overflow
    ovf[ch] = dac_sum[ch][rp_analog_pkg::SUM_DW-1] ^ dac_sum[ch][rp_analog_pkg::SUM_DW-2];

    if (ovf[ch]) begin
      // guard bit holds the true sign
      dac_sat[ch] = dac_sum[ch][rp_analog_pkg::SUM_DW-1] ? rp_analog_pkg::DAC_NEG_MAX
                                                         : rp_analog_pkg::DAC_POS_MAX;
    end else begin
      dac_sat[ch] = dac_sum[ch][rp_analog_pkg::DAC_DW-1:0];
    end

    // converter has a negative slope, flip every code
    dac_inv[ch] = ~dac_sat[ch];
  end
end

////////////////////////////////////////
// two-stage register and swap
////////////////////////////////////////

// stage 1 holds the pre-swap codes also used for loopback
always_ff @(posedge adc_clk) begin
  if (rst_i) begin
    dac_code_o <= '0;
  end else begin
    dac_code_o <= dac_inv;
  end
end

// stage 2 puts ch A out on DAC B and the reverse
always_ff @(posedge adc_clk) begin
  if (rst_i) begin
    dac_dat_o <= '0;
  end else begin
    for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
      dac_dat_o[ch] <= dac_code_o[rp_analog_pkg::N_CH-1-ch];
    end
  end
end

////////////////////////////////////////
// converter reset
////////////////////////////////////////

// held while sequencer waits, released one cycle after run
always_ff @(posedge adc_clk) begin
  if (rst_i) begin
    dac_reset_o <= 1'b1;
  end else begin
    dac_reset_o <= ~run_i;
  end
end

// DAC must be held whenever the sequencer drops run
a_dac_reset_follows_run : assert property (
  @(posedge adc_clk) disable iff (rst_i)
  !run_i |=> dac_reset_o
);

endmodule

// ==== src/adc_frontend.sv ====
`timescale 1ns/10ps

module adc_frontend (
  input  logic                                                     adc_clk,
  input  logic                                                     rst_i,
  input  logic                                                     digital_loop_i,
  input  logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_DW-1:0] adc_dat_i,
  input  logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_code_i,
  output logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] adc_dat_o
);

////////////////////////////////////////
// truncation and channel select
////////////////////////////////////////

// per channel candidates, upper bits only
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] adc_trunc;   // swapped adc
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] loop_trunc;  // same-ch dac
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] sel_dat;

always_comb begin
  for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
    // board wiring crosses the inputs, adc B feeds ch A
    adc_trunc[ch] = adc_dat_i[rp_analog_pkg::N_CH-1-ch]
                    [rp_analog_pkg::ADC_DW-1 -: rp_analog_pkg::ADC_SW];
    // loopback taps the pre-swap dac code of the same channel
    loop_trunc[ch] = dac_code_i[ch][rp_analog_pkg::DAC_DW-1 -: rp_analog_pkg::ADC_SW];
    sel_dat[ch] = digital_loop_i ? loop_trunc[ch] : adc_trunc[ch];
  end
end

////////////////////////////////////////
// output register
////////////////////////////////////////

// one cycle, so loopback lines up with dac_dat_o
always_ff @(posedge adc_clk) begin
  if (rst_i) begin
    adc_dat_o <= '0;
  end else begin
    adc_dat_o <= sel_dat;
  end
end

endmodule

// ==== src/rp_analog_top.sv ====
`timescale 1ns/10ps

module rp_analog_top (
  // clock and reset
  input  logic                                                            adc_clk,
  input  logic                                                            rst_i,
  // readiness from clocking and input delays
  input  logic                                                            pll_locked_i,
  input  logic                                                            idly_rdy_i,
  // configuration
  input  logic                                                            digital_loop_i,
  // converter side
  input  logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_DW-1:0] adc_dat_i,
  // generator and controller samples
  input  logic signed [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] asg_dat_i,
  input  logic signed [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] pid_dat_i,
  // outputs
  output logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] adc_dat_o,
  output logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_dat_o,
  output logic                                                            dac_reset_o,
  output logic                                                            run_o,
  output logic        [rp_analog_pkg::DIAG_W-1:0]                          diag_cnt_o
);

////////////////////////////////////////
// local signals
////////////////////////////////////////

logic count_en;  // PLL unlocked this cycle

// pre-swap dac codes, fed back for loopback
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_code;

////////////////////////////////////////
// sequencing and diagnostics
////////////////////////////////////////

reset_sequencer i_seq (
  .adc_clk      (adc_clk     ),
  .rst_i        (rst_i       ),
  .pll_locked_i (pll_locked_i),
  .idly_rdy_i   (idly_rdy_i  ),
  .run_o        (run_o       ),  // also gates the DAC reset
  .count_en_o   (count_en    )
);

lock_loss_counter i_diag (
  .adc_clk    (adc_clk   ),
  .rst_i      (rst_i     ),
  .count_en_i (count_en  ),
  .diag_cnt_o (diag_cnt_o)
);

////////////////////////////////////////
// DAC path
////////////////////////////////////////

dac_backend i_dac (
  .adc_clk     (adc_clk    ),
  .rst_i       (rst_i      ),
  .run_i       (run_o      ),
  .asg_dat_i   (asg_dat_i  ),
  .pid_dat_i   (pid_dat_i  ),
  .dac_code_o  (dac_code   ),  // to loopback
  .dac_dat_o   (dac_dat_o  ),  // swapped onto the pins
  .dac_reset_o (dac_reset_o)
);

////////////////////////////////////////
// ADC path
////////////////////////////////////////

adc_frontend i_adc (
  .adc_clk        (adc_clk       ),
  .rst_i          (rst_i         ),
  .digital_loop_i (digital_loop_i),
  .adc_dat_i      (adc_dat_i     ),
  .dac_code_i     (dac_code      ),
  .adc_dat_o      (adc_dat_o     )
);

endmodule

// ==== test/tb_rp_analog_checks.svh ====
`ifndef TB_RP_ANALOG_CHECKS_SVH
`define TB_RP_ANALOG_CHECKS_SVH

////////////////////////////////////////
// error line
////////////////////////////////////////

task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
  err_cnt++;
  $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
           $time, sig, exp_v, act_v);
endtask

// converters held and outputs cleared through reset
task automatic expect_reset_values();
  if (cur_test == 1) begin
    chk_cnt += 3;
    if (run_o !== 1'b0) report_mismatch("run_o", 0, run_o);
    if (dac_reset_o !== 1'b1) report_mismatch("dac_reset_o", 1, dac_reset_o);
    if (diag_cnt_o !== '0) report_mismatch("diag_cnt_o", 0, diag_cnt_o);
    if (rst_q) begin  // captured under reset
      chk_cnt += 2;
      if (adc_dat_o !== '0) report_mismatch("adc_dat_o", 0, adc_dat_o);
      if (dac_dat_o !== '0) report_mismatch("dac_dat_o", 0, dac_dat_o);
    end
  end
endtask

// run follows both readiness inputs by one edge and dac reset by two
task automatic compare_run_flags();
  chk_cnt += 2;
  if (run_o !== run_exp) report_mismatch("run_o", run_exp, run_o);
  if (dac_reset_o !== dac_rst_exp) report_mismatch("dac_reset_o", dac_rst_exp, dac_reset_o);
  // advance to the next edge, old run_exp first
  dac_rst_exp = rst_i ? 1'b1 : ~run_exp;
  run_exp     = ~rst_i & pll_locked_i & idly_rdy_i;
endtask

// unlocked edges counted by the model
task automatic tally_lock_loss();
  chk_cnt++;
  if (diag_cnt_o !== lost_cnt) report_mismatch("diag_cnt_o", lost_cnt, diag_cnt_o);
  if (rst_i) begin
    lost_cnt = '0;
  end else if (!pll_locked_i) begin
    lost_cnt = lost_cnt + 1'b1;  // no wrap within this run
  end
endtask

// swapped codes two edges later
task automatic match_dac_codes();
  logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] exp_v;
  exp_v[1] = dac_ref(asg_dat[0], pid_dat[0]);
  exp_v[0] = dac_ref(asg_dat[1], pid_dat[1]);
  if (rst_i) exp_v = '0;
  dac_exp_q.push_back(exp_v);
  dac_exp_ok = 1'b0;
  if (dac_exp_q.size() > 2) begin
    dac_exp_now = dac_exp_q.pop_front();
    dac_exp_ok  = 1'b1;
    for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
      chk_cnt++;
      if (dac_dat_o[ch] !== dac_exp_now[ch])
        report_mismatch($sformatf("dac_dat_o[%0d]", ch), dac_exp_now[ch], dac_dat_o[ch]);
    end
  end
endtask

// crossed adc samples one edge later and skipped for loopback samples
task automatic verify_adc_swap();
  logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] exp_v;
  logic                                                      use_v;
  exp_v[0] = adc_ref(adc_dat, 0);
  exp_v[1] = adc_ref(adc_dat, 1);
  if (rst_i) exp_v = '0;
  adc_exp_q.push_back(exp_v);
  adc_use_q.push_back(~digital_loop_i);
  if (adc_exp_q.size() > 1) begin
    exp_v = adc_exp_q.pop_front();
    use_v = adc_use_q.pop_front();
    for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
      if (use_v) begin
        chk_cnt++;
        if (adc_dat_o[ch] !== exp_v[ch])
          report_mismatch($sformatf("adc_dat_o[%0d]", ch), exp_v[ch], adc_dat_o[ch]);
      end
    end
  end
endtask

// loopback matches the crossed dac output in the same cycle
task automatic loopback_agrees();
  logic [rp_analog_pkg::ADC_SW-1:0] exp_v;
  if (loop_q && dac_exp_ok) begin
    for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
      exp_v = dac_exp_now[rp_analog_pkg::N_CH-1-ch]
              [rp_analog_pkg::DAC_DW-1 -: rp_analog_pkg::ADC_SW];
      chk_cnt++;
      if (adc_dat_o[ch] !== exp_v)
        report_mismatch($sformatf("adc_dat_o[%0d]", ch), exp_v, adc_dat_o[ch]);
    end
  end
endtask

`endif

// ==== test/tb_rp_analog.sv ====
`timescale 1ns/10ps

module tb_rp_analog;

////////////////////////////////////////
// timing and test lengths
////////////////////////////////////////

localparam int CLK_PERIOD = 4;   // ns
localparam int DRIVE_DLY  = 1;   // inputs change this long after posedge
localparam int RST_CYCLES = 10;
localparam int TAIL       = 4;   // settle cycles closing every test
localparam int LEN_IDLE   = 8;
localparam int LEN_SEQ    = 23;  // fixed lock / delay-ready script
localparam int LEN_LOCK   = 200;
localparam int LEN_DAC    = 300;
localparam int LEN_ADC    = 200;
localparam int LEN_LOOP   = 200;
localparam int N_TESTS    = 6;
localparam int MARGIN     = 100;
localparam int WATCHDOG_NS = CLK_PERIOD * (RST_CYCLES + LEN_IDLE + LEN_SEQ + LEN_LOCK
                             + LEN_DAC + LEN_ADC + LEN_LOOP + N_TESTS * TAIL + MARGIN);

////////////////////////////////////////
// DUT signals
////////////////////////////////////////

logic adc_clk;
logic rst_i;
logic pll_locked_i;
logic idly_rdy_i;
logic digital_loop_i;
logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_DW-1:0] adc_dat;
logic signed [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] asg_dat;
logic signed [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] pid_dat;
logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] adc_dat_o;
logic        [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_dat_o;
logic                                                            dac_reset_o;
logic                                                            run_o;
logic        [rp_analog_pkg::DIAG_W-1:0]                          diag_cnt_o;

// bookkeeping
integer seed;
int     cur_test;
int     chk_cnt;
int     err_cnt;
int     chk_mark;
int     err_mark;
int     tests_passed;
int     tests_failed;

// reference models and expected value queues
logic rst_q;        // reset seen at previous negedge
logic loop_q;       // loopback seen at previous negedge
logic run_exp;
logic dac_rst_exp;
logic [rp_analog_pkg::DIAG_W-1:0] lost_cnt;
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_exp_q[$];  // 2 cycle delay
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::DAC_DW-1:0] dac_exp_now;
logic                                                      dac_exp_ok;
logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_SW-1:0] adc_exp_q[$];  // 1 cycle delay
logic                                                      adc_use_q[$];  // off in loopback

rp_analog_top UUT (
  .adc_clk        (adc_clk       ),
  .rst_i          (rst_i         ),
  .pll_locked_i   (pll_locked_i  ),
  .idly_rdy_i     (idly_rdy_i    ),
  .digital_loop_i (digital_loop_i),
  .adc_dat_i      (adc_dat       ),
  .asg_dat_i      (asg_dat       ),
  .pid_dat_i      (pid_dat       ),
  .adc_dat_o      (adc_dat_o     ),
  .dac_dat_o      (dac_dat_o     ),
  .dac_reset_o    (dac_reset_o   ),
  .run_o          (run_o         ),
  .diag_cnt_o     (diag_cnt_o    )
);

initial begin
  adc_clk = 1'b0;
  forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
end

////////////////////////////////////////
// reference functions
////////////////////////////////////////

// clamp to signed 14 bit, then flip for the negative slope
function automatic logic [rp_analog_pkg::DAC_DW-1:0] dac_ref(
  input logic [rp_analog_pkg::DAC_DW-1:0] asg,
  input logic [rp_analog_pkg::DAC_DW-1:0] pid
);
  integer sum;
  integer hi;
  integer lo;
  logic [rp_analog_pkg::DAC_DW-1:0] code;
  hi = (1 << (rp_analog_pkg::DAC_DW - 1)) - 1;
  lo = -hi - 1;
  sum = $signed(asg) + $signed(pid);  // sign extended to 32 bit
  if (sum > hi) begin
    sum = hi;
  end else if (sum < lo) begin
    sum = lo;
  end
  code = sum[rp_analog_pkg::DAC_DW-1:0];
  return ~code;
endfunction

// upper bits of the opposite adc channel
function automatic logic [rp_analog_pkg::ADC_SW-1:0] adc_ref(
  input logic [rp_analog_pkg::N_CH-1:0][rp_analog_pkg::ADC_DW-1:0] adc,
  input int ch
);
  if (ch == 0) begin
    return adc[1][rp_analog_pkg::ADC_DW-1 -: rp_analog_pkg::ADC_SW];
  end else begin
    return adc[0][rp_analog_pkg::ADC_DW-1 -: rp_analog_pkg::ADC_SW];
  end
endfunction

`include "tb_rp_analog_checks.svh"

////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////

task automatic next_cycle();
  @(posedge adc_clk);
  #DRIVE_DLY;
endtask

task automatic finish_test(input string name);
  repeat (TAIL) next_cycle();  // let the pipeline drain
  if (err_cnt == err_mark) begin
    tests_passed++;
  end else begin
    tests_failed++;
  end
  $display("test %0d %s: %0d checks, %0d errors", cur_test, name,
           chk_cnt - chk_mark, err_cnt - err_mark);
  chk_mark = chk_cnt;
  err_mark = err_cnt;
  cur_test++;
endtask

task automatic random_dac_inputs(input int idx);
  integer r;
  for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
    r = $random(seed);
    asg_dat[ch] = r[rp_analog_pkg::DAC_DW-1:0];
    r = $random(seed);
    pid_dat[ch] = r[rp_analog_pkg::DAC_DW-1:0];
  end
  // full scale corners, both directions
  if ((idx % 16) == 0) begin
    asg_dat[0] = 14'h1fff;
    pid_dat[0] = 14'h1fff;
    asg_dat[1] = 14'h2000;
    pid_dat[1] = 14'h2000;
  end
endtask

////////////////////////////////////////
// compare process
////////////////////////////////////////

initial begin
  rst_q       = 1'b1;
  loop_q      = 1'b0;
  run_exp     = 1'b0;
  dac_rst_exp = 1'b1;
  lost_cnt    = '0;
  dac_exp_ok  = 1'b0;
  @(posedge adc_clk);  // first reset capture
  forever begin
    @(negedge adc_clk);  // outputs settled, inputs for next edge stable
    expect_reset_values();
    compare_run_flags();
    tally_lock_loss();
    match_dac_codes();
    verify_adc_swap();
    loopback_agrees();
    rst_q  = rst_i;
    loop_q = digital_loop_i;
  end
end

////////////////////////////////////////
// test sequence
////////////////////////////////////////

initial begin
  integer r;
  seed           = 32'hf747;
  cur_test       = 1;
  chk_cnt        = 0;
  err_cnt        = 0;
  chk_mark       = 0;
  err_mark       = 0;
  tests_passed   = 0;
  tests_failed   = 0;
  rst_i          = 1'b1;
  pll_locked_i   = 1'b1;
  idly_rdy_i     = 1'b0;  // delays not ready, keep converters held
  digital_loop_i = 1'b0;
  adc_dat        = '0;
  asg_dat        = '0;
  pid_dat        = '0;

  repeat (RST_CYCLES) next_cycle();
  rst_i = 1'b0;
  repeat (LEN_IDLE) next_cycle();
  finish_test("reset state");

  // release, then drop lock, then drop delay-ready
  idly_rdy_i = 1'b1;
  repeat (6) next_cycle();
  pll_locked_i = 1'b0;
  repeat (3) next_cycle();
  pll_locked_i = 1'b1;
  repeat (6) next_cycle();
  idly_rdy_i = 1'b0;
  repeat (2) next_cycle();
  idly_rdy_i = 1'b1;
  repeat (6) next_cycle();
  finish_test("sequencing");

  for (int i = 0; i < LEN_LOCK; i++) begin
    r = $random(seed);
    pll_locked_i = (r[1:0] != 2'b00);  // unlocked about a quarter of the time
    next_cycle();
  end
  pll_locked_i = 1'b1;
  finish_test("lock-loss count");

  for (int i = 0; i < LEN_DAC; i++) begin
    random_dac_inputs(i);
    next_cycle();
  end
  finish_test("dac path");

  for (int i = 0; i < LEN_ADC; i++) begin
    for (int ch = 0; ch < rp_analog_pkg::N_CH; ch++) begin
      r = $random(seed);
      adc_dat[ch] = r[rp_analog_pkg::ADC_DW-1:0];
    end
    next_cycle();
  end
  finish_test("adc path");

  digital_loop_i = 1'b1;
  for (int i = 0; i < LEN_LOOP; i++) begin
    random_dac_inputs(i + 1);
    next_cycle();
  end
  digital_loop_i = 1'b0;
  finish_test("loopback");

  $display("tests passed %0d, failed %0d, checks %0d, mismatches %0d",
           tests_passed, tests_failed, chk_cnt, err_cnt);
  if (err_cnt == 0) begin
    $display("*** PASSED ***");
  end else begin
    $display("*** FAILED ***");
  end
  $finish;
end

// ends a hung run
initial begin
  #(WATCHDOG_NS);
  $display("watchdog expired after %0d ns, test %0d never finished", WATCHDOG_NS, cur_test);
  $display("*** FAILED ***");
  $finish;
end

endmodule

// ==== rp_analog.f ====
+incdir+test
src/rp_analog_pkg.sv
src/reset_sequencer.sv
src/lock_loss_counter.sv
src/dac_backend.sv
src/adc_frontend.sv
src/rp_analog_top.sv
test/tb_rp_analog.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the analog front-end testbench with Verilator
set -e

# work from the project root
cd "$(dirname "$0")"

TOP=tb_rp_analog
LOG=sim.log

rm -rf obj_dir "$LOG"

# compile RTL and testbench, assertions enabled
verilator --binary --timing --assert -Wno-fatal \
  -f rp_analog.f \
  --top-module "$TOP"

# run; the log is checked below, a crash leaves no pass line
./obj_dir/V"$TOP" | tee "$LOG"

# pass only when the testbench reported success
if grep -qF "*** PASSED ***" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail, see $LOG"
  exit 1
fi
